//--- Makefile
VERILATOR ?= verilator
TOP       ?= quarkTb
FLIST     ?= all.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FLIST)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- all.f
rtl/quarkPkg.sv
rtl/quarkDecoder.sv
rtl/quarkRegFile.sv
rtl/quarkAlu.sv
rtl/quarkLoadStore.sv
rtl/quarkSequencer.sv
rtl/quarkCore.sv
dv/quarkMem.sv
dv/quarkTb.sv

//--- dv/quarkMem.sv
//**************************************************
// Quark memory model
// 1024 words, one shared port, random read and
// write busy time, store monitor outputs
//**************************************************
`default_nettype none

module quarkMem import quarkPkg::*; (
   input  logic        clk,
   input  memReqT      memReq,
   input  logic        loadImage,
   input  logic [31:0] image [1024],
   output logic [31:0] memRdata,
   output logic        memRbusy,
   output logic        memWbusy,
   output logic        stValid,
   output logic [31:0] stAddr,
   output logic [31:0] stData,
   output logic [3:0]  stMask
);

   timeunit 1ns;
   timeprecision 1ps;

   logic [31:0] words [1024];
   logic [1:0]  rCnt;
   logic [1:0]  wCnt;
   logic [9:0]  wordIdx;
   integer      seed;

   initial begin
      seed     = 32'hdfb35438;
      rCnt     = 2'd0;
      wCnt     = 2'd0;
      memRdata = 32'h0;
      stValid  = 1'b0;
      stAddr   = 32'h0;
      stData   = 32'h0;
      stMask   = 4'h0;
   end

   assign wordIdx  = memReq.addr[11:2];
   assign memRbusy = (rCnt != 2'd0);
   assign memWbusy = (wCnt != 2'd0);

   // Requests are stable mid-cycle, so the model works on the falling edge
   always @(negedge clk) begin
      stValid <= 1'b0;
      if (rCnt != 2'd0) rCnt <= rCnt - 2'd1;
      if (wCnt != 2'd0) wCnt <= wCnt - 2'd1;
      if (loadImage) begin
         for (int i = 0; i < 1024; i++) begin
            words[i] <= image[i];
         end
      end
      // Data is ready at once, busy just hides it for 0 to 3 cycles
      if (memReq.rstrb === 1'b1) begin
         memRdata <= words[wordIdx];
         rCnt     <= 2'($random(seed) & 3);
      end
      if (memReq.wmask !== 4'h0 && !$isunknown(memReq.wmask)) begin
         for (int b = 0; b < 4; b++) begin
            if (memReq.wmask[b]) words[wordIdx][8*b +: 8] <= memReq.wdata[8*b +: 8];
         end
         wCnt    <= 2'($random(seed) & 3);
         // Monitor view of the store
         stValid <= 1'b1;
         stAddr  <= memReq.addr;
         stData  <= memReq.wdata;
         stMask  <= memReq.wmask;
      end
   end

endmodule

`default_nettype wire

//--- dv/quarkTb.sv
//**************************************************
// Quark core testbench
// Assembles a test program, runs it on the core and
// checks every store against a reference model
//**************************************************
`default_nettype none

module quarkTb import quarkPkg::*;;

   timeunit 1ns;
   timeprecision 1ps;

   typedef enum {rAdd, rSub, rAnd, rOr, rXor, rSlt, rSltu, rSll, rSrl, rSra} refOpT;

   typedef struct packed {
      logic [31:0] addr;
      logic [31:0] data;
      logic [3:0]  mask;
   } expStoreT;

   localparam int resultBase = 2048;
   localparam int maxCycles  = 20000;

   logic        clk;
   logic        reset;
   memReqT      memReq;
   logic [31:0] memRdata;
   logic        memRbusy;
   logic        memWbusy;
   logic        loadImage;
   logic [31:0] image [1024];
   logic        stValid;
   logic [31:0] stAddr;
   logic [31:0] stData;
   logic [3:0]  stMask;

   expStoreT    expQ[$];
   int          errors;
   int          cycles;
   int          pcw;
   int          slot;
   integer      seed;
   logic [31:0] opA;
   logic [31:0] opB;

   quarkCore #(.resetAddr(32'h0), .addrWidth(24)) dut (
      .clk      (clk),
      .reset    (reset),
      .memReq   (memReq),
      .memRdata (memRdata),
      .memRbusy (memRbusy),
      .memWbusy (memWbusy)
   );

   quarkMem mem (
      .clk       (clk),
      .memReq    (memReq),
      .loadImage (loadImage),
      .image     (image),
      .memRdata  (memRdata),
      .memRbusy  (memRbusy),
      .memWbusy  (memWbusy),
      .stValid   (stValid),
      .stAddr    (stAddr),
      .stData    (stData),
      .stMask    (stMask)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Instruction formats
   function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, 7'b0110011};
   endfunction

   function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
      return {imm, rs1, f3, rd, opc};
   endfunction

   function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
      return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
   endfunction

   function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
   endfunction

   function automatic logic [31:0] encU(input logic [19:0] imm, input logic [4:0] rd,
                                        input logic [6:0] opc);
      return {imm, rd, opc};
   endfunction

   function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
   endfunction

   // RV32I register-register rules
   function automatic logic [31:0] refResult(input refOpT op, input logic [31:0] x,
                                             input logic [31:0] y);
      case (op)
         rAdd:    return x + y;
         rSub:    return x - y;
         rAnd:    return x & y;
         rOr:     return x | y;
         rXor:    return x ^ y;
         rSlt:    return {31'b0, $signed(x) < $signed(y)};
         rSltu:   return {31'b0, x < y};
         rSll:    return x << y[4:0];
         rSrl:    return x >> y[4:0];
         default: return 32'($signed(x) >>> y[4:0]);
      endcase
   endfunction

   // Branch taken per funct3
   function automatic logic refBranch(input logic [2:0] f3, input logic [31:0] x,
                                      input logic [31:0] y);
      case (f3)
         3'b000:  return x == y;
         3'b001:  return x != y;
         3'b100:  return $signed(x) < $signed(y);
         3'b101:  return $signed(x) >= $signed(y);
         3'b110:  return x < y;
         default: return x >= y;
      endcase
   endfunction

   function automatic logic [31:0] encAluOp(input refOpT op, input logic [4:0] rd);
      logic [2:0] f3;
      logic [6:0] f7;
      f7 = (op == rSub || op == rSra) ? 7'b0100000 : 7'b0;
      case (op)
         rSll:        f3 = 3'b001;
         rSlt:        f3 = 3'b010;
         rSltu:       f3 = 3'b011;
         rXor:        f3 = 3'b100;
         rSrl, rSra:  f3 = 3'b101;
         rOr:         f3 = 3'b110;
         rAnd:        f3 = 3'b111;
         default:     f3 = 3'b000;
      endcase
      return encR(f7, 5'd2, 5'd1, f3, rd);
   endfunction

   task automatic emit(input logic [31:0] w);
      image[pcw] = w;
      pcw++;
   endtask

   task automatic expectStore(input int addr, input logic [31:0] data, input logic [3:0] mask);
      expQ.push_back('{addr: 32'(addr), data: data, mask: mask});
   endtask

   // SW of a register into the next result slot
   task automatic storeResult(input logic [4:0] rs, input logic [31:0] exp);
      emit(encS(12'(4 * slot), rs, 5'd3, 3'b010));
      expectStore(resultBase + 4 * slot, exp, 4'hf);
      slot++;
   endtask

   // LUI plus ADDI with the upper part rounded for the sign of the low 12 bits
   task automatic loadConst(input logic [4:0] rd, input logic [31:0] value);
      logic [31:0] hi;
      hi = (value + 32'h800) >> 12;
      emit(encU(hi[19:0], rd, 7'b0110111));
      emit(encI(value[11:0], rd, 3'b000, rd, 7'b0010011));
   endtask

   task automatic assemble();
      refOpT       op;
      logic [11:0] negImm;
      logic [19:0] upper;
      logic [2:0]  brF3 [5];
      int          sbSlot;
      int          shSlot;
      int          p;
      brF3 = '{3'b100, 3'b101, 3'b110, 3'b111, 3'b000};
      loadConst(5'd1, opA);
      loadConst(5'd2, opB);
      // Result area base in x3
      emit(encI(12'd1024, 5'd0, 3'b000, 5'd3, 7'b0010011));
      emit(encR(7'b0, 5'd3, 5'd3, 3'b000, 5'd3));
      // Register ops with shifts by opB[4:0]
      op = op.first();
      for (int i = 0; i < op.num(); i++) begin
         emit(encAluOp(op, 5'd4));
         storeResult(5'd4, refResult(op, opA, opB));
         op = op.next();
      end
      negImm = 12'(-(($random(seed) & 2047) + 1));
      emit(encI(negImm, 5'd1, 3'b000, 5'd4, 7'b0010011));
      storeResult(5'd4, refResult(rAdd, opA, {{20{negImm[11]}}, negImm}));
      // Byte lanes then read-back
      sbSlot = slot;
      slot++;
      for (int off = 0; off < 4; off++) begin
         emit(encS(12'(4 * sbSlot + off), 5'd1, 5'd3, 3'b000));
         expectStore(resultBase + 4 * sbSlot + off, {4{opA[7:0]}}, 4'(4'b0001 << off));
         emit(encI(12'(4 * sbSlot + off), 5'd3, 3'b000, 5'd4, 7'b0000011));
         storeResult(5'd4, {{24{opA[7]}}, opA[7:0]});
         emit(encI(12'(4 * sbSlot + off), 5'd3, 3'b100, 5'd4, 7'b0000011));
         storeResult(5'd4, {24'b0, opA[7:0]});
      end
      shSlot = slot;
      slot++;
      for (int off = 0; off < 4; off += 2) begin
         emit(encS(12'(4 * shSlot + off), 5'd1, 5'd3, 3'b001));
         expectStore(resultBase + 4 * shSlot + off, {2{opA[15:0]}}, 4'(4'b0011 << off));
         emit(encI(12'(4 * shSlot + off), 5'd3, 3'b001, 5'd4, 7'b0000011));
         storeResult(5'd4, {{16{opA[15]}}, opA[15:0]});
         emit(encI(12'(4 * shSlot + off), 5'd3, 3'b101, 5'd4, 7'b0000011));
         storeResult(5'd4, {16'b0, opA[15:0]});
      end
      // Countdown loop with BNE
      emit(encI(12'd5, 5'd0, 3'b000, 5'd5, 7'b0010011));
      emit(encI(12'd0, 5'd0, 3'b000, 5'd6, 7'b0010011));
      emit(encI(12'd1, 5'd6, 3'b000, 5'd6, 7'b0010011));
      emit(encI(12'hfff, 5'd5, 3'b000, 5'd5, 7'b0010011));
      emit(encB(13'h1ff8, 5'd0, 5'd5, 3'b001));
      storeResult(5'd5, 32'd0);
      storeResult(5'd6, 32'd5);
      // Each taken branch skips the marker
      for (int i = 0; i < 5; i++) begin
         emit(encI(12'd0, 5'd0, 3'b000, 5'd4, 7'b0010011));
         emit(encB(13'd8, 5'd2, 5'd1, brF3[i]));
         emit(encI(12'h05a, 5'd0, 3'b000, 5'd4, 7'b0010011));
         storeResult(5'd4, refBranch(brF3[i], opA, opB) ? 32'd0 : 32'h5a);
      end
      emit(encI(12'd0, 5'd0, 3'b000, 5'd4, 7'b0010011));
      emit(encB(13'd8, 5'd1, 5'd1, 3'b000));
      emit(encI(12'h05a, 5'd0, 3'b000, 5'd4, 7'b0010011));
      storeResult(5'd4, 32'd0);
      // Links and PC-relative values
      p = 4 * pcw;
      emit(encJ(21'd8, 5'd7));
      emit(encI(12'd0, 5'd0, 3'b000, 5'd7, 7'b0010011));
      storeResult(5'd7, 32'(p + 4));
      p = 4 * pcw;
      emit(encU(20'd0, 5'd8, 7'b0010111));
      emit(encI(12'd12, 5'd8, 3'b000, 5'd10, 7'b1100111));
      emit(encI(12'd0, 5'd0, 3'b000, 5'd10, 7'b0010011));
      storeResult(5'd8, 32'(p));
      storeResult(5'd10, 32'(p + 8));
      upper = 20'($random(seed));
      p = 4 * pcw;
      emit(encU(upper, 5'd9, 7'b0010111));
      storeResult(5'd9, 32'(p) + {upper, 12'b0});
      upper = 20'($random(seed));
      emit(encU(upper, 5'd12, 7'b0110111));
      storeResult(5'd12, {upper, 12'b0});
      // Park on a self jump
      emit(encJ(21'd0, 5'd0));
   endtask

   function automatic logic [31:0] laneBits(input logic [3:0] m);
      return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
   endfunction

   // Monitor outputs settle on the falling edge
   always @(posedge clk) begin : compareStores
      expStoreT e;
      if (reset && stValid) begin
         assert (stAddr >= resultBase && stAddr < resultBase + 2048) else begin
            errors++;
            $display("Store outside the result area at address %h", stAddr);
         end
         assert (expQ.size() != 0) else begin
            errors++;
            $display("Store at address %h after all expected stores", stAddr);
         end
         if (expQ.size() != 0) begin
            e = expQ.pop_front();
            assert (stAddr == e.addr) else begin
               errors++;
               $display("ERR memReq.addr exp=%h got=%h", e.addr, stAddr);
            end
            assert (stMask == e.mask) else begin
               errors++;
               $display("ERR memReq.wmask addr=%h exp=%h got=%h", stAddr, e.mask, stMask);
            end
            assert ((stData & laneBits(e.mask)) == (e.data & laneBits(e.mask))) else begin
               errors++;
               $display("ERR memReq.wdata addr=%h exp=%h got=%h", stAddr,
                        e.data & laneBits(e.mask), stData & laneBits(e.mask));
            end
         end
      end
   end

   initial begin
      reset     = 1'b0;
      loadImage = 1'b1;
      errors    = 0;
      cycles    = 0;
      pcw       = 0;
      slot      = 0;
      seed      = 32'hdfb35438;
      for (int i = 0; i < 1024; i++) begin
         image[i] = 32'h0;
      end
      opA = $random(seed);
      opB = $random(seed);
      assemble();
      // Memory copies the image on a falling edge where loadImage is steady high
      repeat (2) @(negedge clk);
      loadImage = 1'b0;
      repeat (2) @(negedge clk);
      reset = 1'b1;
      while (expQ.size() != 0 && cycles < maxCycles) begin
         @(posedge clk);
         cycles++;
      end
      if (expQ.size() != 0) begin
         errors++;
         $display("Timeout: program did not finish, %0d stores never seen", expQ.size());
      end
      // Catch stray stores from the parked loop
      repeat (50) @(posedge clk);
      $display("Errors: %0d", errors);
      if (errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- rtl/quarkAlu.sv
//**************************************************
// Quark ALU
// Adder, subtract-based compare, logic ops, a
// one-bit-per-cycle shifter and branch predicate
//**************************************************
`default_nettype none

module quarkAlu import quarkPkg::*; (
   input  logic            clk,
   input  logic            reset,
   input  logic            start,
   input  decodedInstrT    instr,
   input  logic [xlen-1:0] rs1,
   input  logic [xlen-1:0] rs2,
   output logic [xlen-1:0] aluOut,
   output logic [xlen-1:0] aluSum,
   output logic            takeBranch,
   output logic            aluBusy
);

   logic [xlen-1:0] op2;
   logic [xlen:0]   diff;
   logic            lt;
   logic            ltu;
   logic            eq;
   logic            isAlu;
   logic            isShift;
   logic            predicate;
   logic [xlen-1:0] shiftReg;
   logic [4:0]      shiftCnt;

   assign isAlu   = (instr.opcode == opAluImm) || (instr.opcode == opAluReg);
   assign isShift = isAlu && (instr.funct3[1:0] == 2'b01);

   // Register and branch ops compare rs2, the rest take the immediate
   assign op2 = (instr.opcode == opAluReg || instr.opcode == opBranch) ?
                rs2 : instr.imm;

   // Also the JALR target
   assign aluSum = rs1 + op2;

   // One 33-bit subtract for SUB and every compare
   assign diff = {1'b0, rs1} - {1'b0, op2};
   assign ltu  = diff[xlen];
   // Signs differ, so the negative one is smaller
   assign lt   = (rs1[xlen-1] ^ op2[xlen-1]) ? rs1[xlen-1] : diff[xlen];
   assign eq   = (diff[xlen-1:0] == '0);

   always_comb begin
      case (instr.funct3)
         // Bit 30 of ADDI belongs to the immediate
         3'b000:  aluOut = (instr.altFunct && instr.opcode == opAluReg) ?
                           diff[xlen-1:0] : aluSum;
         3'b010:  aluOut = {{(xlen-1){1'b0}}, lt};
         3'b011:  aluOut = {{(xlen-1){1'b0}}, ltu};
         3'b100:  aluOut = rs1 ^ op2;
         3'b110:  aluOut = rs1 | op2;
         3'b111:  aluOut = rs1 & op2;
         // SLL, SRL and SRA
         default: aluOut = shiftReg;
      endcase
   end

   always_comb begin
      case (instr.funct3)
         3'b000:  predicate = eq;
         3'b001:  predicate = !eq;
         3'b100:  predicate = lt;
         3'b101:  predicate = !lt;
         3'b110:  predicate = ltu;
         3'b111:  predicate = !ltu;
         default: predicate = 1'b0;
      endcase
   end

   assign takeBranch = (instr.opcode == opBranch) && predicate;

   // Busy while shift steps remain
   assign aluBusy = (shiftCnt != 5'd0);

   always_ff @(posedge clk) begin
      if (!reset) begin
         shiftCnt <= 5'd0;
      end else if (start && isShift) begin
         shiftCnt <= op2[4:0];
      end else if (aluBusy) begin
         shiftCnt <= shiftCnt - 5'd1;
      end
   end

   // funct3 001 shifts left, 101 shifts right with bit 30 picking SRA
   always_ff @(posedge clk) begin
      if (start && isShift) begin
         shiftReg <= rs1;
      end else if (aluBusy) begin
         shiftReg <= (instr.funct3 == 3'b001) ? {shiftReg[xlen-2:0], 1'b0} :
                     {instr.altFunct & shiftReg[xlen-1], shiftReg[xlen-1:1]};
      end
   end

   // The sequencer must not restart a shift still in progress
   assert property (@(posedge clk) disable iff (!reset) start |-> !aluBusy);

endmodule

`default_nettype wire

//--- rtl/quarkCore.sv
//**************************************************
// Quark core top level
// Minimal multicycle RV32I with one shared memory
// port for instructions and data
//**************************************************
`default_nettype none

module quarkCore import quarkPkg::*; #(
   parameter logic [31:0] resetAddr = 32'h0,
   parameter int          addrWidth = 24
) (
   input  logic            clk,
   input  logic            reset,
   output memReqT          memReq,
   input  logic [xlen-1:0] memRdata,
   input  logic            memRbusy,
   input  logic            memWbusy
);

   decodedInstrT         instr;
   logic                 loadInstr;
   logic                 aluStart;
   logic                 storeEn;
   logic                 regWriteEn;
   logic [xlen-1:0]      regWriteData;
   logic [xlen-1:0]      rs1;
   logic [xlen-1:0]      rs2;
   logic [xlen-1:0]      aluOut;
   logic [xlen-1:0]      aluSum;
   logic                 takeBranch;
   logic                 aluBusy;
   logic [addrWidth-1:0] lsAddr;
   logic [xlen-1:0]      storeData;
   logic [3:0]           storeMask;
   logic [xlen-1:0]      loadData;

   quarkDecoder decoder (
      .clk       (clk),
      .loadInstr (loadInstr),
      .memRdata  (memRdata),
      .instr     (instr)
   );

   // Source indices come straight off the incoming word
   quarkRegFile regFile (
      .clk     (clk),
      .readEn  (loadInstr),
      .rs1Id   (memRdata[19:15]),
      .rs2Id   (memRdata[24:20]),
      .writeEn (regWriteEn),
      .rdId    (instr.rd),
      .rdData  (regWriteData),
      .rs1     (rs1),
      .rs2     (rs2)
   );

   quarkAlu alu (
      .clk        (clk),
      .reset      (reset),
      .start      (aluStart),
      .instr      (instr),
      .rs1        (rs1),
      .rs2        (rs2),
      .aluOut     (aluOut),
      .aluSum     (aluSum),
      .takeBranch (takeBranch),
      .aluBusy    (aluBusy)
   );

   quarkLoadStore #(.addrWidth(addrWidth)) loadStore (
      .instr    (instr),
      .rs1      (rs1),
      .rs2      (rs2),
      .storeEn  (storeEn),
      .memRdata (memRdata),
      .lsAddr   (lsAddr),
      .wdata    (storeData),
      .wmask    (storeMask),
      .loadData (loadData)
   );

   quarkSequencer #(.resetAddr(resetAddr), .addrWidth(addrWidth)) sequencer (
      .clk          (clk),
      .reset        (reset),
      .instr        (instr),
      .memRbusy     (memRbusy),
      .memWbusy     (memWbusy),
      .aluOut       (aluOut),
      .aluSum       (aluSum),
      .loadData     (loadData),
      .takeBranch   (takeBranch),
      .aluBusy      (aluBusy),
      .lsAddr       (lsAddr),
      .storeData    (storeData),
      .storeMask    (storeMask),
      .loadInstr    (loadInstr),
      .aluStart     (aluStart),
      .storeEn      (storeEn),
      .regWriteEn   (regWriteEn),
      .regWriteData (regWriteData),
      .memReq       (memReq)
   );

endmodule

`default_nettype wire

//--- rtl/quarkDecoder.sv
//**************************************************
// Quark instruction decoder
// Latches the fetched word and splits it into the
// opcode, rd, function fields and immediate
//**************************************************
`default_nettype none

module quarkDecoder import quarkPkg::*; (
   input  logic         clk,
   input  logic         loadInstr,
   input  logic [31:0]  memRdata,
   output decodedInstrT instr
);

   opcodeT      opcode;
   logic [31:0] imm;

   // Opcode from bits 6 to 2 since bits 1 and 0 are always 11 in RV32I
   always_comb begin
      case (memRdata[6:2])
         5'b00000: opcode = opLoad;
         5'b00100: opcode = opAluImm;
         5'b01000: opcode = opStore;
         5'b01100: opcode = opAluReg;
         5'b11011: opcode = opJal;
         5'b11001: opcode = opJalr;
         5'b01101: opcode = opLui;
         5'b00101: opcode = opAuipc;
         5'b11000: opcode = opBranch;
         // Anything else runs as a no-op
         default:  opcode = opIllegal;
      endcase
   end

   // Immediate format per opcode with I format as the fallback
   always_comb begin
      case (opcode)
         opStore:
            imm = {{21{memRdata[31]}}, memRdata[30:25], memRdata[11:7]};
         opBranch:
            imm = {{20{memRdata[31]}}, memRdata[7], memRdata[30:25],
                   memRdata[11:8], 1'b0};
         opJal:
            imm = {{12{memRdata[31]}}, memRdata[19:12], memRdata[20],
                   memRdata[30:21], 1'b0};
         opLui, opAuipc:
            imm = {memRdata[31:12], 12'b0};
         default:
            imm = {{21{memRdata[31]}}, memRdata[30:20]};
      endcase
   end

   // Held for the whole instruction
   always_ff @(posedge clk) begin
      if (loadInstr) begin
         instr <= '{opcode:   opcode,
                    rd:       memRdata[11:7],
                    funct3:   memRdata[14:12],
                    altFunct: memRdata[30],
                    imm:      imm,
                    pad:      6'b0};
      end
   end

   // An unknown word would decode silently as a no-op
   assert property (@(posedge clk) loadInstr |-> !$isunknown(memRdata));

endmodule

`default_nettype wire

//--- rtl/quarkLoadStore.sv
//**************************************************
// Quark load/store unit
// Effective address, store lane replication and
// mask, load lane extraction with sign extension
//**************************************************
`default_nettype none

module quarkLoadStore import quarkPkg::*; #(
   parameter int addrWidth = 24
) (
   input  decodedInstrT         instr,
   input  logic [xlen-1:0]      rs1,
   input  logic [xlen-1:0]      rs2,
   input  logic                 storeEn,
   input  logic [xlen-1:0]      memRdata,
   output logic [addrWidth-1:0] lsAddr,
   output logic [xlen-1:0]      wdata,
   output logic [3:0]           wmask,
   output logic [xlen-1:0]      loadData
);

   logic        byteAcc;
   logic        halfAcc;
   logic [3:0]  laneMask;
   logic [15:0] loadHalf;
   logic [7:0]  loadByte;
   logic        loadSign;

   // Decoder already picked S or I immediate
   assign lsAddr = rs1[addrWidth-1:0] + instr.imm[addrWidth-1:0];

   // funct3 low bits: 00 byte, 01 halfword, 10 word
   assign byteAcc = (instr.funct3[1:0] == 2'b00);
   assign halfAcc = (instr.funct3[1:0] == 2'b01);

   // Each lane gets whichever rs2 byte may land there
   assign wdata[7:0]   = rs2[7:0];
   assign wdata[15:8]  = lsAddr[0] ? rs2[7:0] : rs2[15:8];
   assign wdata[23:16] = lsAddr[1] ? rs2[7:0] : rs2[23:16];
   assign wdata[31:24] = lsAddr[0] ? rs2[7:0] :
                         lsAddr[1] ? rs2[15:8] : rs2[31:24];

   always_comb begin
      if (byteAcc) begin
         laneMask = 4'b0001 << lsAddr[1:0];
      end else if (halfAcc) begin
         laneMask = lsAddr[1] ? 4'b1100 : 4'b0011;
      end else begin
         laneMask = 4'b1111;
      end
   end

   // Mask only during the store strobe
   assign wmask = storeEn ? laneMask : 4'b0000;

   // Pick the addressed halfword, then the byte within it
   assign loadHalf = lsAddr[1] ? memRdata[31:16] : memRdata[15:0];
   assign loadByte = lsAddr[0] ? loadHalf[15:8] : loadHalf[7:0];

   // LBU and LHU have funct3 bit 2 set
   assign loadSign = !instr.funct3[2] & (byteAcc ? loadByte[7] : loadHalf[15]);

   assign loadData = byteAcc ? {{24{loadSign}}, loadByte} :
                     halfAcc ? {{16{loadSign}}, loadHalf} :
                     memRdata;

endmodule

`default_nettype wire

//--- rtl/quarkPkg.sv
//**************************************************
// Quark core shared definitions
// Opcode and sequencer state encodings, the decoded
// instruction word and the memory request bundle
//**************************************************
`default_nettype none

package quarkPkg;

   // Data word and register index widths
   localparam int xlen        = 32;
   localparam int regIdxWidth = 5;

   // Major opcodes of RV32I, minus SYSTEM and FENCE
   typedef enum logic [3:0] {
      opLoad,
      opAluImm,
      opStore,
      opAluReg,
      opJal,
      opJalr,
      opLui,
      opAuipc,
      opBranch,
      opIllegal
   } opcodeT;

   // Multicycle sequence of every instruction
   typedef enum logic [1:0] {
      stFetch,
      stWaitInstr,
      stExecute,
      stWaitAluMem
   } seqStateT;

   // Instruction after decode, 51 bits
   typedef struct packed {
      opcodeT      opcode;
      logic [4:0]  rd;
      logic [2:0]  funct3;
      // Bit 30, SUB or SRA
      logic        altFunct;
      // Already selected for the format and sign-extended
      logic [31:0] imm;
      logic [5:0]  pad;
   } decodedInstrT;

   // Shared instruction and data port, 69 bits
   typedef struct packed {
      logic [31:0] addr;
      logic [31:0] wdata;
      logic [3:0]  wmask;
      logic        rstrb;
   } memReqT;

endpackage

`default_nettype wire

//--- rtl/quarkRegFile.sv
//**************************************************
// Quark register file
// 32 x 32-bit, x0 reads zero, registered dual read
//**************************************************
`default_nettype none

module quarkRegFile import quarkPkg::*; (
   input  logic                   clk,
   input  logic                   readEn,
   input  logic [regIdxWidth-1:0] rs1Id,
   input  logic [regIdxWidth-1:0] rs2Id,
   input  logic                   writeEn,
   input  logic [regIdxWidth-1:0] rdId,
   input  logic [xlen-1:0]        rdData,
   output logic [xlen-1:0]        rs1,
   output logic [xlen-1:0]        rs2
);

   logic [xlen-1:0] regs [2**regIdxWidth];

   // Writes to x0 are dropped
   always_ff @(posedge clk) begin
      if (writeEn && rdId != '0) begin
         regs[rdId] <= rdData;
      end
   end

   // Read ports sample the indices of the word being fetched
   // x0 is forced to zero since its entry is never written
   always_ff @(posedge clk) begin
      if (readEn) begin
         rs1 <= (rs1Id == '0) ? '0 : regs[rs1Id];
         rs2 <= (rs2Id == '0) ? '0 : regs[rs2Id];
      end
   end

endmodule

`default_nettype wire

//--- rtl/quarkSequencer.sv
//**************************************************
// Quark sequencer
// Four-state machine, program counter, memory
// request assembly and register writeback select
//**************************************************
`default_nettype none

module quarkSequencer import quarkPkg::*; #(
   parameter logic [31:0] resetAddr = 32'h0,
   parameter int          addrWidth = 24
) (
   input  logic                 clk,
   input  logic                 reset,
   input  decodedInstrT         instr,
   input  logic                 memRbusy,
   input  logic                 memWbusy,
   input  logic [xlen-1:0]      aluOut,
   input  logic [xlen-1:0]      aluSum,
   input  logic [xlen-1:0]      loadData,
   input  logic                 takeBranch,
   input  logic                 aluBusy,
   input  logic [addrWidth-1:0] lsAddr,
   input  logic [xlen-1:0]      storeData,
   input  logic [3:0]           storeMask,
   output logic                 loadInstr,
   output logic                 aluStart,
   output logic                 storeEn,
   output logic                 regWriteEn,
   output logic [xlen-1:0]      regWriteData,
   output memReqT               memReq
);

   seqStateT             state;
   logic [addrWidth-1:0] pc;
   logic [addrWidth-1:0] pcPlus4;
   logic [addrWidth-1:0] nextPc;
   logic [xlen-1:0]      pcPlusImm;
   logic                 isLoad;
   logic                 isStore;
   logic                 isAlu;
   logic                 needWait;
   logic                 writesRd;
   logic                 waitWrite;

   assign isLoad  = (instr.opcode == opLoad);
   assign isStore = (instr.opcode == opStore);
   assign isAlu   = (instr.opcode == opAluImm) || (instr.opcode == opAluReg);

   // Loads, stores and shifts finish in the wait state
   assign needWait = isLoad || isStore || (isAlu && instr.funct3[1:0] == 2'b01);
   assign writesRd = !(isStore || instr.opcode == opBranch ||
                       instr.opcode == opIllegal);

   // Full width so AUIPC keeps its upper bits
   assign pcPlusImm = xlen'(pc) + instr.imm;
   assign pcPlus4   = pc + addrWidth'(4);

   always_comb begin
      if (instr.opcode == opJalr) begin
         nextPc = {aluSum[addrWidth-1:1], 1'b0};
      end else if (instr.opcode == opJal || takeBranch) begin
         nextPc = pcPlusImm[addrWidth-1:0];
      end else begin
         nextPc = pcPlus4;
      end
   end

   // Starts in the wait state until the memory is idle
   always_ff @(posedge clk) begin
      if (!reset) begin
         state     <= stWaitAluMem;
         pc        <= resetAddr[addrWidth-1:0];
         waitWrite <= 1'b0;
      end else begin
         case (state)
            stFetch: begin
               state <= stWaitInstr;
            end
            stWaitInstr: begin
               if (!memRbusy) begin
                  state <= stExecute;
               end
            end
            stExecute: begin
               pc        <= nextPc;
               waitWrite <= needWait && writesRd;
               state     <= needWait ? stWaitAluMem : stFetch;
            end
            default: begin
               if (!aluBusy && !memRbusy && !memWbusy) begin
                  state <= stFetch;
               end
            end
         endcase
      end
   end

   // Decoder and register file sample the word as it arrives
   assign loadInstr = (state == stWaitInstr) && !memRbusy;
   assign aluStart  = (state == stExecute) && isAlu;
   assign storeEn   = (state == stExecute) && isStore;

   // Waiting writes repeat each cycle so the last one holds the settled value
   assign regWriteEn = ((state == stExecute) && writesRd && !needWait) ||
                       ((state == stWaitAluMem) && waitWrite);

   always_comb begin
      case (instr.opcode)
         opLui:         regWriteData = instr.imm;
         opAuipc:       regWriteData = pcPlusImm;
         opJal, opJalr: regWriteData = xlen'(pcPlus4);
         opLoad:        regWriteData = loadData;
         default:       regWriteData = aluOut;
      endcase
   end

   // PC while fetching, load/store address otherwise
   // Upper address bits read as zero
   always_comb begin
      memReq.addr  = 32'((state == stFetch || state == stWaitInstr) ? pc : lsAddr);
      memReq.wdata = storeData;
      memReq.wmask = storeMask;
      memReq.rstrb = (state == stFetch) || ((state == stExecute) && isLoad);
   end

   // Store mask comes from the load/store unit, only one cycle per store
   assert property (@(posedge clk) disable iff (!reset)
                    state != stExecute |-> memReq.wmask == 4'b0000);

endmodule

`default_nettype wire
